// ==== cam_capture_pkg.sv ====
`default_nettype none

package cam_capture_pkg;

   // Pixel sample widths
   typedef logic [7:0]  pix8_t;
   // Upper byte carries the second pixel of the pair
   typedef logic [15:0] pix2_t;

   // Packed pair {b1,g1,r1,b0,g0,r0}
   typedef logic [47:0] fifo_word_t;
   typedef logic [63:0] dma_data_t;
   typedef logic [31:0] stat_word_t;

   // Beats per DMA transfer, must match the firmware transfer length
   localparam int unsigned DMA_BURST_LEN = 32;
   typedef logic [$clog2(DMA_BURST_LEN)-1:0] burst_cnt_t;

   localparam int unsigned FIFO_DEPTH = 64;
   typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_addr_t;

   // Flops on each control input coming from the CPU side
   localparam int unsigned SYNC_STAGES = 2;

   // Nominal mipi_pclk rate
   localparam int unsigned PCLK_RATE_HZ = 75_000_000;

endpackage

`default_nettype wire

// ==== cam_frame_capture.sv ====
`timescale 1ns/10ps
`default_nettype none

module cam_frame_capture (
   input  logic                   mipi_pclk,
   input  logic                   rst_n,
   input  logic                   cam_vsync_i,
   input  logic                   cam_valid_i,
   input  cam_capture_pkg::pix2_t cam_r_pix_i,
   input  cam_capture_pkg::pix2_t cam_g_pix_i,
   input  cam_capture_pkg::pix2_t cam_b_pix_i,
   input  logic                   trigger_capture_i,
   input  logic                   continuous_capture_i,
   input  logic                   rgb_gray_i,
   input  logic                   fifo_wr_i,
   output logic                   pix_valid_o,
   output cam_capture_pkg::pix2_t r_pix_o,
   output cam_capture_pkg::pix2_t g_pix_o,
   output cam_capture_pkg::pix2_t b_pix_o,
   output logic                   gray_mode_o,
   output logic                   vs_fall_o
);

   import cam_capture_pkg::*;

   typedef enum logic {
      CAP_IDLE,
      CAP_FRAME
   } cap_state_t;

   cap_state_t             cap_state;
   logic [SYNC_STAGES-1:0] trig_sync;
   logic                   trig_last;
   logic [SYNC_STAGES-1:0] cont_sync;
   logic [SYNC_STAGES-1:0] gray_sync;
   logic                   trig_hold;
   logic                   cont_hold;
   logic                   vsync_d;
   logic                   trig_rise;

   assign trig_rise = trig_sync[SYNC_STAGES-1] & ~trig_last;

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         trig_sync <= '0;
         trig_last <= 1'b0;
         cont_sync <= '0;
         gray_sync <= '0;
         trig_hold <= 1'b0;
         cont_hold <= 1'b0;
         vsync_d   <= 1'b0;
         vs_fall_o <= 1'b0;
         cap_state <= CAP_IDLE;
      end else begin
         trig_sync <= {trig_sync[SYNC_STAGES-2:0], trigger_capture_i};
         trig_last <= trig_sync[SYNC_STAGES-1];
         cont_sync <= {cont_sync[SYNC_STAGES-2:0], continuous_capture_i};
         gray_sync <= {gray_sync[SYNC_STAGES-2:0], rgb_gray_i};

         // A new trigger wins over the clear from the first written word
         if (trig_rise) begin
            trig_hold <= 1'b1;
         end else if (fifo_wr_i) begin
            trig_hold <= 1'b0;
         end
         if (cont_sync[SYNC_STAGES-1]) begin
            cont_hold <= 1'b1;
         end

         vsync_d   <= cam_vsync_i;
         vs_fall_o <= vsync_d & ~cam_vsync_i;

         // Frame boundaries only
         if (vs_fall_o) begin
            if (trig_hold || cont_hold) begin
               cap_state <= CAP_FRAME;
            end else begin
               cap_state <= CAP_IDLE;
            end
         end
      end
   end

   assign pix_valid_o = cam_valid_i && (cap_state == CAP_FRAME);
   assign r_pix_o     = cam_r_pix_i;
   assign g_pix_o     = cam_g_pix_i;
   assign b_pix_o     = cam_b_pix_i;
   assign gray_mode_o = gray_sync[SYNC_STAGES-1];

endmodule

`default_nettype wire

// ==== cam_pixel_pack.sv ====
`timescale 1ns/10ps
`default_nettype none

module cam_pixel_pack (
   input  logic                        mipi_pclk,
   input  logic                        rst_n,
   input  logic                        pix_valid_i,
   input  cam_capture_pkg::pix2_t      r_pix_i,
   input  cam_capture_pkg::pix2_t      g_pix_i,
   input  cam_capture_pkg::pix2_t      b_pix_i,
   input  logic                        gray_mode_i,
   output logic                        fifo_wr_o,
   output cam_capture_pkg::fifo_word_t fifo_wdata_o
);

   import cam_capture_pkg::*;

   pix8_t      gray0;
   pix8_t      gray1;
   fifo_word_t word_rgb;
   fifo_word_t word_gray;

   // Luma approximation (r + 2g + b) / 4, truncated
   function automatic pix8_t to_gray(input pix8_t r, input pix8_t g, input pix8_t b);
      logic [9:0] sum;
      sum = {2'b00, r} + {1'b0, g, 1'b0} + {2'b00, b};
      return sum[9:2];
   endfunction

   assign gray0 = to_gray(r_pix_i[7:0], g_pix_i[7:0], b_pix_i[7:0]);
   assign gray1 = to_gray(r_pix_i[15:8], g_pix_i[15:8], b_pix_i[15:8]);

   assign word_rgb  = {b_pix_i[15:8], g_pix_i[15:8], r_pix_i[15:8],
                       b_pix_i[7:0], g_pix_i[7:0], r_pix_i[7:0]};
   assign word_gray = {gray1, gray1, gray1, gray0, gray0, gray0};

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         fifo_wr_o <= 1'b0;
      end else begin
         fifo_wr_o <= pix_valid_i;
      end
   end

   always_ff @(posedge mipi_pclk) begin
      if (pix_valid_i) begin
         fifo_wdata_o <= gray_mode_i ? word_gray : word_rgb;
      end
   end

endmodule

`default_nettype wire

// ==== cam_dma_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module cam_dma_fifo (
   input  logic                        mipi_pclk,
   input  logic                        rst_n,
   input  logic                        wr_i,
   input  cam_capture_pkg::fifo_word_t wdata_i,
   input  logic                        rd_i,
   output cam_capture_pkg::fifo_word_t rdata_o,
   output logic                        empty_o,
   output logic                        overflow_o
);

   import cam_capture_pkg::*;

   fifo_word_t                  mem [FIFO_DEPTH];
   fifo_addr_t                  wr_ptr;
   fifo_addr_t                  rd_ptr;
   logic [$clog2(FIFO_DEPTH):0] count;
   logic                        full;
   logic                        wr_ok;
   logic                        rd_ok;

   assign full    = (count == FIFO_DEPTH);
   assign empty_o = (count == '0);
   assign wr_ok   = wr_i && !full;
   assign rd_ok   = rd_i && !empty_o;

   // Word written while full is lost
   assign overflow_o = wr_i && full;

   // Head word is visible without a read request
   assign rdata_o = mem[rd_ptr];

   always_ff @(posedge mipi_pclk) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wdata_i;
      end
   end

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== cam_dma_writer.sv ====
`timescale 1ns/10ps
`default_nettype none

module cam_dma_writer (
   input  logic                        mipi_pclk,
   input  logic                        rst_n,
   input  logic                        dma_init_done_i,
   input  logic                        dma_wready_i,
   input  logic                        fifo_empty_i,
   input  cam_capture_pkg::fifo_word_t fifo_rdata_i,
   output logic                        fifo_rd_o,
   output logic                        dma_write_o,
   output logic                        dma_wvalid_o,
   output logic                        dma_wlast_o,
   output cam_capture_pkg::dma_data_t  dma_wdata_o
);

   import cam_capture_pkg::*;

   typedef enum logic {
      DMA_IDLE,
      DMA_ARMED
   } dma_state_t;

   dma_state_t dma_state;
   // Init-done crosses from the CPU side through three flops
   logic [2:0] init_sync;
   logic       init_rise;
   burst_cnt_t beat_cnt;
   logic       last_beat;

   assign init_rise = init_sync[1] & ~init_sync[2];
   assign last_beat = (beat_cnt == burst_cnt_t'(DMA_BURST_LEN - 1));

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         init_sync <= '0;
         dma_state <= DMA_IDLE;
         beat_cnt  <= '0;
      end else begin
         init_sync <= {init_sync[1:0], dma_init_done_i};

         if (init_rise) begin
            dma_state <= DMA_ARMED;
         end else if (fifo_rd_o && last_beat) begin
            dma_state <= DMA_IDLE;
         end

         if (fifo_rd_o) begin
            beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
         end
      end
   end

   assign dma_write_o  = (dma_state == DMA_ARMED);
   assign fifo_rd_o    = dma_write_o && dma_wready_i && !fifo_empty_i;
   assign dma_wvalid_o = fifo_rd_o;
   assign dma_wlast_o  = fifo_rd_o && last_beat;

   // One zero byte above each 24-bit pixel
   assign dma_wdata_o = {8'd0, fifo_rdata_i[47:24], 8'd0, fifo_rdata_i[23:0]};

endmodule

`default_nettype wire

// ==== cam_stats.sv ====
`timescale 1ns/10ps
`default_nettype none

module cam_stats #(
   parameter int unsigned CLK_RATE_HZ = cam_capture_pkg::PCLK_RATE_HZ
) (
   input  logic                        mipi_pclk,
   input  logic                        rst_n,
   input  logic                        fifo_wr_i,
   input  logic                        fifo_rd_i,
   input  logic                        fifo_overflow_i,
   input  logic                        fifo_empty_i,
   input  logic                        dma_write_i,
   input  logic                        dma_wready_i,
   input  logic                        vs_fall_i,
   output cam_capture_pkg::stat_word_t fifo_wcount_o,
   output cam_capture_pkg::stat_word_t fifo_rcount_o,
   output cam_capture_pkg::stat_word_t fifo_status_o,
   output cam_capture_pkg::stat_word_t frames_per_second_o
);

   import cam_capture_pkg::*;

   logic       overflow_seen;
   stat_word_t timer_cnt;
   stat_word_t frame_cnt;
   logic       window_end;

   // One measurement window is CLK_RATE_HZ+1 cycles
   assign window_end = (timer_cnt == stat_word_t'(CLK_RATE_HZ));

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         fifo_wcount_o       <= '0;
         fifo_rcount_o       <= '0;
         overflow_seen       <= 1'b0;
         timer_cnt           <= '0;
         frame_cnt           <= '0;
         frames_per_second_o <= '0;
      end else begin
         if (fifo_wr_i) begin
            fifo_wcount_o <= fifo_wcount_o + 1'b1;
         end
         if (fifo_rd_i) begin
            fifo_rcount_o <= fifo_rcount_o + 1'b1;
         end
         if (fifo_overflow_i) begin
            overflow_seen <= 1'b1;
         end

         if (window_end) begin
            timer_cnt           <= '0;
            frame_cnt           <= '0;
            frames_per_second_o <= frame_cnt;
         end else begin
            timer_cnt <= timer_cnt + 1'b1;
            if (vs_fall_i) begin
               frame_cnt <= frame_cnt + 1'b1;
            end
         end
      end
   end

   assign fifo_status_o = {28'd0, overflow_seen, fifo_empty_i, dma_write_i, dma_wready_i};

endmodule

`default_nettype wire

// ==== cam_capture_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module cam_capture_top #(
   parameter int unsigned CLK_RATE_HZ = cam_capture_pkg::PCLK_RATE_HZ
) (
   input  logic                        mipi_pclk,
   input  logic                        rst_n,
   input  logic                        cam_vsync_i,
   input  logic                        cam_valid_i,
   input  cam_capture_pkg::pix2_t      cam_r_pix_i,
   input  cam_capture_pkg::pix2_t      cam_g_pix_i,
   input  cam_capture_pkg::pix2_t      cam_b_pix_i,
   input  logic                        trigger_capture_i,
   input  logic                        continuous_capture_i,
   input  logic                        rgb_gray_i,
   input  logic                        cam_dma_wready_i,
   input  logic                        cam_dma_init_done_i,
   output logic                        cam_dma_wvalid_o,
   output logic                        cam_dma_wlast_o,
   output cam_capture_pkg::dma_data_t  cam_dma_wdata_o,
   output cam_capture_pkg::stat_word_t frames_per_second_o,
   output cam_capture_pkg::stat_word_t debug_fifo_rcount_o,
   output cam_capture_pkg::stat_word_t debug_fifo_wcount_o,
   output cam_capture_pkg::stat_word_t debug_fifo_status_o
);

   import cam_capture_pkg::*;

   logic       pix_valid;
   pix2_t      r_pix;
   pix2_t      g_pix;
   pix2_t      b_pix;
   logic       gray_mode;
   logic       vs_fall;
   logic       fifo_wr;
   fifo_word_t fifo_wdata;
   logic       fifo_rd;
   fifo_word_t fifo_rdata;
   logic       fifo_empty;
   logic       fifo_overflow;
   logic       dma_write;

   cam_frame_capture u_frame_capture (
      .mipi_pclk            (mipi_pclk),
      .rst_n                (rst_n),
      .cam_vsync_i          (cam_vsync_i),
      .cam_valid_i          (cam_valid_i),
      .cam_r_pix_i          (cam_r_pix_i),
      .cam_g_pix_i          (cam_g_pix_i),
      .cam_b_pix_i          (cam_b_pix_i),
      .trigger_capture_i    (trigger_capture_i),
      .continuous_capture_i (continuous_capture_i),
      .rgb_gray_i           (rgb_gray_i),
      .fifo_wr_i            (fifo_wr),
      .pix_valid_o          (pix_valid),
      .r_pix_o              (r_pix),
      .g_pix_o              (g_pix),
      .b_pix_o              (b_pix),
      .gray_mode_o          (gray_mode),
      .vs_fall_o            (vs_fall)
   );

   cam_pixel_pack u_pixel_pack (
      .mipi_pclk    (mipi_pclk),
      .rst_n        (rst_n),
      .pix_valid_i  (pix_valid),
      .r_pix_i      (r_pix),
      .g_pix_i      (g_pix),
      .b_pix_i      (b_pix),
      .gray_mode_i  (gray_mode),
      .fifo_wr_o    (fifo_wr),
      .fifo_wdata_o (fifo_wdata)
   );

   cam_dma_fifo u_dma_fifo (
      .mipi_pclk  (mipi_pclk),
      .rst_n      (rst_n),
      .wr_i       (fifo_wr),
      .wdata_i    (fifo_wdata),
      .rd_i       (fifo_rd),
      .rdata_o    (fifo_rdata),
      .empty_o    (fifo_empty),
      .overflow_o (fifo_overflow)
   );

   cam_dma_writer u_dma_writer (
      .mipi_pclk       (mipi_pclk),
      .rst_n           (rst_n),
      .dma_init_done_i (cam_dma_init_done_i),
      .dma_wready_i    (cam_dma_wready_i),
      .fifo_empty_i    (fifo_empty),
      .fifo_rdata_i    (fifo_rdata),
      .fifo_rd_o       (fifo_rd),
      .dma_write_o     (dma_write),
      .dma_wvalid_o    (cam_dma_wvalid_o),
      .dma_wlast_o     (cam_dma_wlast_o),
      .dma_wdata_o     (cam_dma_wdata_o)
   );

   cam_stats #(
      .CLK_RATE_HZ (CLK_RATE_HZ)
   ) u_stats (
      .mipi_pclk           (mipi_pclk),
      .rst_n               (rst_n),
      .fifo_wr_i           (fifo_wr),
      .fifo_rd_i           (fifo_rd),
      .fifo_overflow_i     (fifo_overflow),
      .fifo_empty_i        (fifo_empty),
      .dma_write_i         (dma_write),
      .dma_wready_i        (cam_dma_wready_i),
      .vs_fall_i           (vs_fall),
      .fifo_wcount_o       (debug_fifo_wcount_o),
      .fifo_rcount_o       (debug_fifo_rcount_o),
      .fifo_status_o       (debug_fifo_status_o),
      .frames_per_second_o (frames_per_second_o)
   );

endmodule

`default_nettype wire

// ==== tb_cam_capture_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_cam_capture_top;

   import cam_capture_pkg::*;

   localparam int unsigned TB_CLK_RATE  = 400;
   localparam int          WINDOW_CYC   = TB_CLK_RATE + 1;
   localparam int          FRAME_CYC    = 16;
   localparam int          PH_TRIG_CYC  = 3 * FRAME_CYC + 20;
   localparam int          PH_GRAY_CYC  = FRAME_CYC + 20;
   localparam int          PH_BURST_CYC = 6 * FRAME_CYC + 8 * DMA_BURST_LEN + 60;
   localparam int          PH_OVF_CYC   = 10 * FRAME_CYC + 2 * DMA_BURST_LEN + 60;
   localparam int          PH_FPS_CYC   = 5 * WINDOW_CYC;
   localparam int          TIMEOUT_CYC  = 2 * (10 + PH_TRIG_CYC + PH_GRAY_CYC + PH_BURST_CYC
                                                + PH_OVF_CYC + PH_FPS_CYC);

   // One pixel pair with its mode and the packed word it must produce
   typedef struct packed {
      logic       mode;
      pix2_t      r;
      pix2_t      g;
      pix2_t      b;
      fifo_word_t exp;
   } row_t;

   logic       mipi_pclk;
   logic       rst_n;
   logic       cam_vsync_i;
   logic       cam_valid_i;
   pix2_t      cam_r_pix_i;
   pix2_t      cam_g_pix_i;
   pix2_t      cam_b_pix_i;
   logic       trigger_capture_i;
   logic       continuous_capture_i;
   logic       rgb_gray_i;
   logic       cam_dma_wready_i;
   logic       cam_dma_init_done_i;
   logic       cam_dma_wvalid_o;
   logic       cam_dma_wlast_o;
   dma_data_t  cam_dma_wdata_o;
   stat_word_t frames_per_second_o;
   stat_word_t debug_fifo_rcount_o;
   stat_word_t debug_fifo_wcount_o;
   stat_word_t debug_fifo_status_o;

   row_t        rows [16];
   dma_data_t   exp_q [$];
   int          beats      = 0;
   int          exp_wcount = 0;
   int          keep_cnt   = 1_000_000;
   int          cyc_cnt    = 0;
   int          pclk_cnt   = 0;
   logic        stall_en   = 1'b0;
   logic [31:0] rnd_state  = 32'h4748d848;

   cam_capture_top #(
      .CLK_RATE_HZ (TB_CLK_RATE)
   ) i_cam_capture_top (
      .mipi_pclk            (mipi_pclk),
      .rst_n                (rst_n),
      .cam_vsync_i          (cam_vsync_i),
      .cam_valid_i          (cam_valid_i),
      .cam_r_pix_i          (cam_r_pix_i),
      .cam_g_pix_i          (cam_g_pix_i),
      .cam_b_pix_i          (cam_b_pix_i),
      .trigger_capture_i    (trigger_capture_i),
      .continuous_capture_i (continuous_capture_i),
      .rgb_gray_i           (rgb_gray_i),
      .cam_dma_wready_i     (cam_dma_wready_i),
      .cam_dma_init_done_i  (cam_dma_init_done_i),
      .cam_dma_wvalid_o     (cam_dma_wvalid_o),
      .cam_dma_wlast_o      (cam_dma_wlast_o),
      .cam_dma_wdata_o      (cam_dma_wdata_o),
      .frames_per_second_o  (frames_per_second_o),
      .debug_fifo_rcount_o  (debug_fifo_rcount_o),
      .debug_fifo_wcount_o  (debug_fifo_wcount_o),
      .debug_fifo_status_o  (debug_fifo_status_o)
   );

   initial begin
      mipi_pclk = 1'b0;
      forever #5 mipi_pclk = ~mipi_pclk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Zero byte above each 24-bit pixel on the DMA bus
   function automatic dma_data_t pad_to_dma(input fifo_word_t w);
      return {8'h00, w[47:24], 8'h00, w[23:0]};
   endfunction

   task automatic end_with_failure();
      $display("Test failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_data(input string name, input dma_data_t got, input dma_data_t exp);
      if (got !== exp) begin
         $display("ERROR time=%0t %s got=%h expected=%h", $time, name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic check_last(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR time=%0t %s got=%b expected=%b", $time, name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic check_stat(input string name, input stat_word_t got, input stat_word_t exp);
      if (got !== exp) begin
         $display("ERROR time=%0t %s got=%h expected=%h", $time, name, got, exp);
         end_with_failure();
      end
   endtask

   // Rows 0-7 RGB frame, rows 8-15 gray frame
   task automatic load_table();
      rows[0]  = {1'b0, 16'h1020, 16'h3040, 16'h5060, 48'h503010_604020};
      rows[1]  = {1'b0, 16'hff00, 16'h00ff, 16'h8001, 48'h8000ff_01ff00};
      rows[2]  = {1'b0, 16'h0102, 16'h0304, 16'h0506, 48'h050301_060402};
      rows[3]  = {1'b0, 16'hdead, 16'hbeef, 16'hcafe, 48'hcabede_feefad};
      rows[4]  = {1'b0, 16'h1234, 16'h5678, 16'h9abc, 48'h9a5612_bc7834};
      rows[5]  = {1'b0, 16'h0000, 16'h0000, 16'h0000, 48'h000000_000000};
      rows[6]  = {1'b0, 16'hffff, 16'hffff, 16'hffff, 48'hffffff_ffffff};
      rows[7]  = {1'b0, 16'ha5c3, 16'h5a3c, 16'h0f1e, 48'h0f5aa5_1e3cc3};
      rows[8]  = {1'b1, 16'h1020, 16'h3040, 16'h5060, 48'h303030_404040};
      rows[9]  = {1'b1, 16'hffff, 16'hffff, 16'hffff, 48'hffffff_ffffff};
      rows[10] = {1'b1, 16'h0000, 16'h0000, 16'h0000, 48'h000000_000000};
      rows[11] = {1'b1, 16'h0301, 16'h0001, 16'h0001, 48'h000000_010101};
      rows[12] = {1'b1, 16'hff00, 16'h00ff, 16'h80ff, 48'h5f5f5f_bfbfbf};
      rows[13] = {1'b1, 16'h6407, 16'h3203, 16'h0a02, 48'h343434_030303};
      rows[14] = {1'b1, 16'hc8fe, 16'hc8fe, 16'hc8fe, 48'hc8c8c8_fefefe};
      rows[15] = {1'b1, 16'h01ff, 16'h02ff, 16'h0300, 48'h020202_bfbfbf};
   endtask

   // Advance to the next falling edge, where all inputs change
   task automatic wait_cycle();
      @(negedge mipi_pclk);
      if (stall_en) begin
         rnd_state        = xorshift32(rnd_state);
         cam_dma_wready_i = (rnd_state[1:0] != 2'b00);
      end
   endtask

   task automatic pulse_trigger();
      trigger_capture_i = 1'b1;
      repeat (2) wait_cycle();
      trigger_capture_i = 1'b0;
      repeat (6) wait_cycle();
   endtask

   task automatic pulse_init_done();
      cam_dma_init_done_i = 1'b1;
      repeat (2) wait_cycle();
      cam_dma_init_done_i = 1'b0;
      repeat (6) wait_cycle();
   endtask

   // Vsync fall, then eight pixel pairs from the table or from the generator
   task automatic drive_frame(input int first_row, input logic from_table, input logic captured);
      pix2_t      r;
      pix2_t      g;
      pix2_t      b;
      fifo_word_t exp_word;
      if (from_table) begin
         rgb_gray_i = rows[first_row].mode;
      end
      cam_vsync_i = 1'b1;
      repeat (3) wait_cycle();
      cam_vsync_i = 1'b0;
      repeat (3) wait_cycle();
      for (int i = 0; i < 8; i++) begin
         if (from_table) begin
            r        = rows[first_row + i].r;
            g        = rows[first_row + i].g;
            b        = rows[first_row + i].b;
            exp_word = rows[first_row + i].exp;
         end else begin
            rnd_state = xorshift32(rnd_state);
            r         = rnd_state[15:0];
            g         = rnd_state[31:16];
            rnd_state = xorshift32(rnd_state);
            b         = rnd_state[15:0];
            exp_word  = {b[15:8], g[15:8], r[15:8], b[7:0], g[7:0], r[7:0]};
         end
         cam_valid_i = 1'b1;
         cam_r_pix_i = r;
         cam_g_pix_i = g;
         cam_b_pix_i = b;
         if (captured) begin
            exp_wcount++;
            if (keep_cnt > 0) begin
               exp_q.push_back(pad_to_dma(exp_word));
               keep_cnt--;
            end
         end
         wait_cycle();
      end
      cam_valid_i = 1'b0;
      repeat (2) wait_cycle();
   endtask

   task automatic drive_vsync_falls(input int n);
      repeat (n) begin
         cam_vsync_i = 1'b1;
         repeat (4) wait_cycle();
         cam_vsync_i = 1'b0;
         repeat (4) wait_cycle();
      end
   endtask

   task automatic wait_beats(input int n);
      while (beats < n) begin
         wait_cycle();
      end
   endtask

   task automatic wait_window_offset(input int off);
      while ((pclk_cnt % WINDOW_CYC) != off) begin
         wait_cycle();
      end
   endtask

   task automatic check_queue_drained();
      if (exp_q.size() != 0) begin
         $display("%0d captured words never reached the DMA port", exp_q.size());
         end_with_failure();
      end
   endtask

   always @(posedge mipi_pclk) begin
      cyc_cnt <= cyc_cnt + 1;
      if (cyc_cnt >= TIMEOUT_CYC) begin
         $display("Timeout after %0d cycles, the DUT stopped making progress", cyc_cnt);
         end_with_failure();
      end
   end

   // Mirrors the DUT timer so FPS windows can be located
   always @(posedge mipi_pclk) begin
      if (rst_n) begin
         pclk_cnt <= pclk_cnt + 1;
      end
   end

   // A beat transfers when wvalid is high at the rising edge
   always @(posedge mipi_pclk) begin : dma_sink
      dma_data_t exp_data;
      if (rst_n && cam_dma_wvalid_o) begin
         if (exp_q.size() == 0) begin
            $display("DMA beat at %0t with no captured word left to send", $time);
            end_with_failure();
         end else begin
            exp_data = exp_q.pop_front();
            check_data("cam_dma_wdata_o", cam_dma_wdata_o, exp_data);
            check_last("cam_dma_wlast_o", cam_dma_wlast_o,
                       ((beats % DMA_BURST_LEN) == DMA_BURST_LEN - 1));
            beats = beats + 1;
         end
      end else if (rst_n) begin
         check_last("cam_dma_wlast_o", cam_dma_wlast_o, 1'b0);
      end
   end

   initial begin
      rst_n                = 1'b0;
      cam_vsync_i          = 1'b0;
      cam_valid_i          = 1'b0;
      cam_r_pix_i          = '0;
      cam_g_pix_i          = '0;
      cam_b_pix_i          = '0;
      trigger_capture_i    = 1'b0;
      continuous_capture_i = 1'b0;
      rgb_gray_i           = 1'b0;
      cam_dma_wready_i     = 1'b1;
      cam_dma_init_done_i  = 1'b0;
      load_table();

      repeat (5) wait_cycle();
      rst_n = 1'b1;
      wait_cycle();
      check_last("cam_dma_wvalid_o", cam_dma_wvalid_o, 1'b0);
      check_stat("debug_fifo_wcount_o", debug_fifo_wcount_o, '0);
      check_stat("debug_fifo_rcount_o", debug_fifo_rcount_o, '0);
      check_stat("frames_per_second_o", frames_per_second_o, '0);

      // Single trigger takes only the frame after the next vsync fall
      drive_frame(0, 1'b0, 1'b0);
      pulse_trigger();
      drive_frame(0, 1'b1, 1'b1);
      drive_frame(0, 1'b0, 1'b0);
      repeat (4) wait_cycle();
      check_stat("debug_fifo_wcount_o", debug_fifo_wcount_o, stat_word_t'(exp_wcount));

      // Gray frame
      pulse_trigger();
      drive_frame(8, 1'b1, 1'b1);
      repeat (4) wait_cycle();
      check_stat("debug_fifo_wcount_o", debug_fifo_wcount_o, stat_word_t'(exp_wcount));

      // Continuous capture, bursts and random wready stalls
      rgb_gray_i           = 1'b0;
      continuous_capture_i = 1'b1;
      repeat (6) wait_cycle();
      drive_frame(0, 1'b0, 1'b1);
      check_stat("debug_fifo_rcount_o", debug_fifo_rcount_o, '0);
      stall_en = 1'b1;
      pulse_init_done();
      repeat (5) drive_frame(0, 1'b0, 1'b1);
      wait_beats(DMA_BURST_LEN);
      repeat (20) wait_cycle();
      check_stat("debug_fifo_rcount_o", debug_fifo_rcount_o, stat_word_t'(DMA_BURST_LEN));
      pulse_init_done();
      wait_beats(2 * DMA_BURST_LEN);
      stall_en         = 1'b0;
      cam_dma_wready_i = 1'b1;
      repeat (4) wait_cycle();
      check_queue_drained();
      check_stat("debug_fifo_rcount_o", debug_fifo_rcount_o, stat_word_t'(2 * DMA_BURST_LEN));
      check_stat("debug_fifo_wcount_o", debug_fifo_wcount_o, stat_word_t'(exp_wcount));

      // Overflow with wready held low drops the words past FIFO_DEPTH
      cam_dma_wready_i = 1'b0;
      keep_cnt         = FIFO_DEPTH;
      repeat (10) drive_frame(0, 1'b0, 1'b1);
      repeat (4) wait_cycle();
      check_stat("debug_fifo_wcount_o", debug_fifo_wcount_o, stat_word_t'(exp_wcount));
      check_stat("debug_fifo_status_o", debug_fifo_status_o, 32'h0000_0008);
      pulse_init_done();
      check_stat("debug_fifo_status_o", debug_fifo_status_o, 32'h0000_000a);
      cam_dma_wready_i = 1'b1;
      wait_beats(3 * DMA_BURST_LEN);
      repeat (4) wait_cycle();
      check_stat("debug_fifo_status_o", debug_fifo_status_o, 32'h0000_0009);
      pulse_init_done();
      wait_beats(4 * DMA_BURST_LEN);
      repeat (4) wait_cycle();
      check_stat("debug_fifo_status_o", debug_fifo_status_o, 32'h0000_000d);
      check_stat("debug_fifo_rcount_o", debug_fifo_rcount_o, stat_word_t'(4 * DMA_BURST_LEN));
      check_queue_drained();

      // Frames per second over two full windows
      wait_window_offset(200);
      wait_window_offset(10);
      drive_vsync_falls(5);
      wait_window_offset(5);
      check_stat("frames_per_second_o", frames_per_second_o, 32'd5);
      wait_window_offset(10);
      drive_vsync_falls(9);
      wait_window_offset(5);
      check_stat("frames_per_second_o", frames_per_second_o, 32'd9);

      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// ==== cam_capture_top.f ====
cam_capture_pkg.sv
cam_frame_capture.sv
cam_pixel_pack.sv
cam_dma_fifo.sv
cam_dma_writer.sv
cam_stats.sv
cam_capture_top.sv
tb_cam_capture_top.sv
